//--- hdl/imgFilter_defs.svh
`ifndef IMG_FILTER_DEFS_SVH
`define IMG_FILTER_DEFS_SVH

// source and frame image size in pixels
`define IMG_W 16
`define IMG_H 12

// grey value width
`define PIX_W 8

// horizontal timing, pixels per region
`define H_ACTIVE 16
`define H_FRONT 2
`define H_SYNC 3
`define H_BACK 3

// vertical timing, lines per region
`define V_ACTIVE 12
`define V_FRONT 1
`define V_SYNC 2
`define V_BACK 2

// clocks per pixel
`define PIX_DIV 2
`endif

//--- hdl/imgFilterPkg.sv
`include "imgFilter_defs.svh"

package imgFilterPkg;

	// 3x3 kernels, encoding follows the select priority
	typedef enum logic [1:0] {
		kIdentity = 2'd0,
		kBlur = 2'd1,
		kSharpen = 2'd2,
		kEdge = 2'd3
	} kernelT;

	// one grey sample
	typedef logic [`PIX_W-1:0] pixelT;

	// linear raster address into the frame
	typedef logic [$clog2(`IMG_W * `IMG_H)-1:0] pixAddrT;

	// fixed source image
	// diagonal ramp with a small xor texture, wraps at 8 bits
	function automatic pixelT srcPixel(input int x, input int y);
		int ramp;
		int texture;
		ramp = x * 15 + y * 19;
		// sharp steps so edge and sharpen have something to find
		texture = ((x ^ y) & 7) * 23;
		return pixelT'(ramp + texture);
	endfunction

endpackage

//--- hdl/convEngine.sv
`timescale 1ns/1ps
`include "imgFilter_defs.svh"

module convEngine import imgFilterPkg::*; (
	input logic CLK,
	input logic rstN,
	input logic identity,
	input logic kernel1,
	input logic kernel2,
	input logic kernel3,
	output logic wrEn,
	output pixAddrT wrAddr,
	output pixelT wrData,
	output logic filterDone
);

	// edge filter reaches 8 * 255, blur 16 * 255
	localparam int SUM_W = `PIX_W + 5;
	localparam int X_LAST = `IMG_W - 1;
	localparam int Y_LAST = `IMG_H - 1;
	localparam pixAddrT LAST_ADDR = pixAddrT'(`IMG_W * `IMG_H - 1);
	localparam logic signed [SUM_W-1:0] PIX_MAX = SUM_W'((1 << `PIX_W) - 1);

	kernelT kSel;
	kernelT selKernel;
	logic change;
	logic running;
	logic [$clog2(`IMG_W)-1:0] xCnt;
	logic [$clog2(`IMG_H)-1:0] yCnt;
	pixAddrT curAddr;

	// stage one results
	logic s1Valid;
	logic signed [SUM_W-1:0] sumNext;
	logic signed [SUM_W-1:0] s1Sum;
	kernelT s1Kernel;
	pixAddrT s1Addr;

	pixelT pixNext;

	// saturate a signed sum into the grey range
	function automatic pixelT clampPix(input logic signed [SUM_W-1:0] v);
		if (v < 0)
			return '0;
		if (v > PIX_MAX)
			return pixelT'(PIX_MAX);
		return pixelT'(v);
	endfunction

	// priority select, falls back to the current kernel
	always_comb begin
		if (kernel1)
			selKernel = kBlur;
		else if (kernel2)
			selKernel = kSharpen;
		else if (kernel3)
			selKernel = kEdge;
		else if (identity)
			selKernel = kIdentity;
		else
			selKernel = kSel;
	end

	// same kernel again is ignored
	assign change = (selKernel != kSel);

	// raster issue counter, one pixel per clock while running
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			kSel <= kIdentity;
			running <= 1'b1;
			xCnt <= '0;
			yCnt <= '0;
		end else if (change) begin
			kSel <= selKernel;
			running <= 1'b1;
			xCnt <= '0;
			yCnt <= '0;
		end else if (running) begin
			if (xCnt == X_LAST) begin
				xCnt <= '0;
				// stop after the bottom right pixel
				if (yCnt == Y_LAST)
					running <= 1'b0;
				else
					yCnt <= yCnt + 1'b1;
			end else begin
				xCnt <= xCnt + 1'b1;
			end
		end
	end

	assign curAddr = pixAddrT'(int'(yCnt) * `IMG_W + int'(xCnt));

	// stage one: clamped 3x3 window and weighted sum
	always_comb begin
		int xc, xm, xp, yc, ym, yp;
		pixelT pC, pN, pS, pW, pE, pNW, pNE, pSW, pSE;
		logic signed [SUM_W-1:0] centre, edgeSum, cornerSum;
		xc = int'(xCnt);
		yc = int'(yCnt);
		// neighbours held at the image border
		xm = (xc == 0) ? 0 : xc - 1;
		xp = (xc == X_LAST) ? X_LAST : xc + 1;
		ym = (yc == 0) ? 0 : yc - 1;
		yp = (yc == Y_LAST) ? Y_LAST : yc + 1;
		pC = srcPixel(xc, yc);
		pN = srcPixel(xc, ym);
		pS = srcPixel(xc, yp);
		pW = srcPixel(xm, yc);
		pE = srcPixel(xp, yc);
		pNW = srcPixel(xm, ym);
		pNE = srcPixel(xp, ym);
		pSW = srcPixel(xm, yp);
		pSE = srcPixel(xp, yp);
		centre = SUM_W'(pC);
		edgeSum = SUM_W'(pN) + SUM_W'(pS) + SUM_W'(pW) + SUM_W'(pE);
		cornerSum = SUM_W'(pNW) + SUM_W'(pNE) + SUM_W'(pSW) + SUM_W'(pSE);
		case (kSel)
			kIdentity: sumNext = centre;
			// 1-2-1 by 1-2-1, divided later
			kBlur: sumNext = (centre <<< 2) + (edgeSum <<< 1) + cornerSum;
			kSharpen: sumNext = (centre <<< 2) + centre - edgeSum;
			default: sumNext = (centre <<< 3) - edgeSum - cornerSum;
		endcase
	end

	// stage two: normalize or clamp to a grey value
	always_comb begin
		logic signed [SUM_W-1:0] absSum;
		absSum = s1Sum[SUM_W-1] ? -s1Sum : s1Sum;
		case (s1Kernel)
			kIdentity: pixNext = pixelT'(s1Sum);
			kBlur: pixNext = pixelT'(s1Sum >>> 4);
			kSharpen: pixNext = clampPix(s1Sum);
			default: pixNext = clampPix(absSum);
		endcase
	end

	// valid bits, flushed on a kernel change so an aborted pass gives no done
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
			wrEn <= 1'b0;
			filterDone <= 1'b0;
		end else begin
			s1Valid <= running && !change;
			wrEn <= s1Valid && !change;
			filterDone <= wrEn && (wrAddr == LAST_ADDR);
		end
	end

	// pipeline payload
	always_ff @(posedge CLK) begin
		s1Sum <= sumNext;
		s1Kernel <= kSel;
		s1Addr <= curAddr;
		wrData <= pixNext;
		wrAddr <= s1Addr;
	end

endmodule

//--- hdl/frameBuffer.sv
`timescale 1ns/1ps
`include "imgFilter_defs.svh"

module frameBuffer import imgFilterPkg::*; (
	input logic CLK,
	input logic wrEn,
	input pixAddrT wrAddr,
	input pixelT wrData,
	input pixAddrT rdAddr,
	output pixelT rdData
);

	localparam int DEPTH = `IMG_W * `IMG_H;

	// one grey sample per frame pixel
	pixelT mem [DEPTH];

	// write side, driven by the filter pipeline
	always_ff @(posedge CLK) begin
		if (wrEn)
			mem[wrAddr] <= wrData;
	end

	// read side for the scanner
	// data returns on the clock after the address
	always_ff @(posedge CLK) begin
		rdData <= mem[rdAddr];
	end

endmodule

//--- hdl/videoScanner.sv
`timescale 1ns/1ps
`include "imgFilter_defs.svh"

module videoScanner import imgFilterPkg::*; (
	input logic CLK,
	input logic rstN,
	output pixAddrT rdAddr,
	input pixelT rdData,
	output logic hsync,
	output logic vsync,
	output logic blank,
	output pixelT grey
);

	localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
	localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
	localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
	localparam int DIV_W = $clog2(`PIX_DIV + 1);

	logic [DIV_W-1:0] divCnt;
	logic pixStrobe;
	logic [$clog2(H_TOTAL)-1:0] hCnt;
	logic [$clog2(V_TOTAL)-1:0] vCnt;
	logic active;
	logic hsyncNext;
	logic vsyncNext;

	// pixel strobe every PIX_DIV clocks
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			divCnt <= '0;
		else if (pixStrobe)
			divCnt <= '0;
		else
			divCnt <= divCnt + 1'b1;
	end

	assign pixStrobe = (divCnt == DIV_W'(`PIX_DIV - 1));

	// line and frame position
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			hCnt <= '0;
			vCnt <= '0;
		end else if (pixStrobe) begin
			if (hCnt == H_TOTAL - 1) begin
				hCnt <= '0;
				vCnt <= (vCnt == V_TOTAL - 1) ? '0 : vCnt + 1'b1;
			end else begin
				hCnt <= hCnt + 1'b1;
			end
		end
	end

	// decode of the counter position, shown one pixel later
	assign active = (hCnt < `H_ACTIVE) && (vCnt < `V_ACTIVE);
	assign hsyncNext = !((hCnt >= H_SYNC_START) && (hCnt < H_SYNC_START + `H_SYNC));
	assign vsyncNext = !((vCnt >= V_SYNC_START) && (vCnt < V_SYNC_START + `V_SYNC));

	// read one pixel ahead so rdData is settled at the strobe
	assign rdAddr = active ? pixAddrT'(int'(vCnt) * `IMG_W + int'(hCnt)) : '0;

	// registered video outputs
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			blank <= 1'b0;
			grey <= '0;
		end else if (pixStrobe) begin
			hsync <= hsyncNext;
			vsync <= vsyncNext;
			blank <= active;
			// black outside the visible area
			grey <= active ? rdData : '0;
		end
	end

endmodule

//--- hdl/imgFilter.sv
`timescale 1ns/1ps

module imgFilter import imgFilterPkg::*; (
	input logic CLK,
	input logic rstN,
	input logic identity,
	input logic kernel1,
	input logic kernel2,
	input logic kernel3,
	output logic hsync,
	output logic vsync,
	output logic blank,
	output logic filterDone,
	output pixelT r,
	output pixelT g,
	output pixelT b
);

	// write link, engine to buffer
	logic wrEn;
	pixAddrT wrAddr;
	pixelT wrData;

	// read link, scanner to buffer
	pixAddrT rdAddr;
	pixelT rdData;
	pixelT grey;

	convEngine u_conv (.CLK, .rstN, .identity, .kernel1, .kernel2, .kernel3,
		.wrEn, .wrAddr, .wrData, .filterDone);

	frameBuffer u_fb (.CLK, .wrEn, .wrAddr, .wrData, .rdAddr, .rdData);

	videoScanner u_scan (.CLK, .rstN, .rdAddr, .rdData, .hsync, .vsync, .blank, .grey);

	// grey image, same value on every channel
	assign r = grey;
	assign g = grey;
	assign b = grey;

endmodule

//--- bench/imgFilter_chk.sv
`timescale 1ns/1ps
`include "imgFilter_defs.svh"

module imgFilter_chk import imgFilterPkg::*; (
	input logic CLK,
	input logic rstN,
	input logic hsync,
	input logic vsync,
	input logic blank,
	input logic filterDone,
	input pixelT r
);

	// one full pass plus pipeline drain
	localparam int GAP_MIN = `IMG_W * `IMG_H + 2;

	// read by the testbench summary
	int failCount = 0;
	int gap;

	// clocks since the last done pulse, saturating
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			gap <= GAP_MIN;
		else if (filterDone)
			gap <= 1;
		else if (gap < GAP_MIN)
			gap <= gap + 1;
	end

	// three sync pixels at two clocks each
	hsyncWidth: assert property (@(posedge CLK) disable iff (!rstN)
		$fell(hsync) |-> !hsync [*6] ##1 hsync)
		else begin
			$error("hsync pulse is not 6 clocks wide");
			failCount++;
		end

	// vertical sync lines are never visible
	blankInVsync: assert property (@(posedge CLK) disable iff (!rstN)
		!vsync |-> !blank)
		else begin
			$error("blank high during vsync");
			failCount++;
		end

	// black outside the active area
	blackInBlank: assert property (@(posedge CLK) disable iff (!rstN)
		!blank |-> (r == '0))
		else begin
			$error("red channel not zero while blank is low");
			failCount++;
		end

	// at most one done per pass length
	doneSpacing: assert property (@(posedge CLK) disable iff (!rstN)
		filterDone |-> (gap >= GAP_MIN))
		else begin
			$error("filterDone repeated within one pass length");
			failCount++;
		end

endmodule

bind imgFilter imgFilter_chk u_chk (.CLK, .rstN, .hsync, .vsync, .blank, .filterDone, .r);

//--- bench/imgFilterTb.sv
`timescale 1ns/1ps
`include "imgFilter_defs.svh"

module imgFilterTb import imgFilterPkg::*; ();

	localparam int FRAME_PIX = `IMG_W * `IMG_H;
	localparam int PASS_CLKS = FRAME_PIX + 2;
	localparam int LINE_CLKS = `PIX_DIV * (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK);
	localparam int FRAME_CLKS = LINE_CLKS * (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);
	localparam int RAND_STEPS = 6;
	// timing, identity, three kernels, priority, restart, random steps
	localparam int NUM_TESTS = 7 + RAND_STEPS;
	localparam int LIMIT_CLKS = 2 * NUM_TESTS * (PASS_CLKS + 2 * FRAME_CLKS);

	logic CLK, rstN, identity, kernel1, kernel2, kernel3;
	logic hsync, vsync, blank, filterDone;
	pixelT r, g, b;

	int mismatchCount = 0;
	int otherCount = 0;
	int doneCount = 0;
	int seed;
	string testName;
	kernelT expKernel;
	logic capReq = 1'b0;
	logic cmpReq = 1'b0;
	pixelT gotR [FRAME_PIX];
	pixelT gotG [FRAME_PIX];
	pixelT gotB [FRAME_PIX];

	imgFilter u_dut (.CLK, .rstN, .identity, .kernel1, .kernel2, .kernel3,
		.hsync, .vsync, .blank, .filterDone, .r, .g, .b);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// filter rules on the fixed source pattern, borders clamped
	function automatic int refPixel(input kernelT k, input int x, input int y);
		int xm, xp, ym, yp, c, e, n, acc;
		xm = (x > 0) ? x - 1 : 0;
		xp = (x < `IMG_W - 1) ? x + 1 : `IMG_W - 1;
		ym = (y > 0) ? y - 1 : 0;
		yp = (y < `IMG_H - 1) ? y + 1 : `IMG_H - 1;
		c = int'(srcPixel(x, y));
		e = int'(srcPixel(x, ym)) + int'(srcPixel(x, yp));
		e += int'(srcPixel(xm, y)) + int'(srcPixel(xp, y));
		n = int'(srcPixel(xm, ym)) + int'(srcPixel(xp, ym));
		n += int'(srcPixel(xm, yp)) + int'(srcPixel(xp, yp));
		case (k)
			kIdentity: acc = c;
			kBlur: acc = (4 * c + 2 * e + n) / 16;
			kSharpen: acc = 5 * c - e;
			default: begin
				acc = 8 * c - e - n;
				if (acc < 0)
					acc = -acc;
			end
		endcase
		if (acc < 0)
			acc = 0;
		if (acc > 255)
			acc = 255;
		return acc;
	endfunction

	// sel bits: 0 identity, 1 kernel1, 2 kernel2, 3 kernel3
	function automatic kernelT nextKernel(input logic [3:0] sel, input kernelT cur);
		if (sel[1])
			return kBlur;
		if (sel[2])
			return kSharpen;
		if (sel[3])
			return kEdge;
		if (sel[0])
			return kIdentity;
		return cur;
	endfunction

	function automatic logic [3:0] selFor(input kernelT k);
		return 4'b0001 << int'(k);
	endfunction

	// done pulses seen, sampled mid cycle
	always @(negedge CLK) begin
		if (rstN && filterDone)
			doneCount++;
	end

	// one clock select pulse
	task automatic pulseSel(input logic [3:0] sel);
		@(posedge CLK);
		identity <= sel[0];
		kernel1 <= sel[1];
		kernel2 <= sel[2];
		kernel3 <= sel[3];
		@(posedge CLK);
		{identity, kernel1, kernel2, kernel3} <= 4'b0000;
	endtask

	task automatic waitDone(input int snap);
		while (doneCount <= snap)
			@(posedge CLK);
	endtask

	// hand one frame to capture and compare, block until both finish
	task automatic checkFrame(input string name, input kernelT k);
		testName = name;
		expKernel = k;
		capReq = 1'b1;
		wait (!capReq && !cmpReq);
	endtask

	task automatic runKernel(input string name, input logic [3:0] sel, input kernelT k);
		int snap;
		snap = doneCount;
		pulseSel(sel);
		waitDone(snap);
		checkFrame(name, k);
	endtask

	// capture: next full active frame after vsync returns high
	initial begin
		int idx;
		logic phase;
		forever begin
			wait (capReq);
			@(negedge CLK);
			while (vsync !== 1'b0)
				@(negedge CLK);
			while (vsync !== 1'b1)
				@(negedge CLK);
			idx = 0;
			phase = 1'b0;
			// each pixel is held for two clocks, keep the first
			while (idx < FRAME_PIX) begin
				@(negedge CLK);
				if (blank) begin
					if (!phase) begin
						gotR[idx] = r;
						gotG[idx] = g;
						gotB[idx] = b;
						idx++;
					end
					phase = !phase;
				end
			end
			cmpReq = 1'b1;
			capReq = 1'b0;
		end
	end

	// compare against the reference filter
	initial begin
		int expVal;
		forever begin
			wait (cmpReq);
			for (int i = 0; i < FRAME_PIX; i++) begin
				expVal = refPixel(expKernel, i % `IMG_W, i / `IMG_W);
				assert (int'(gotR[i]) == expVal && int'(gotG[i]) == expVal
					&& int'(gotB[i]) == expVal)
				else begin
					mismatchCount++;
					$display("MISMATCH %s pixel (%0d,%0d) expected %0d actual r=%0d g=%0d b=%0d",
						testName, i % `IMG_W, i / `IMG_W, expVal, gotR[i], gotG[i], gotB[i]);
				end
			end
			cmpReq = 1'b0;
		end
	end

	initial begin
		repeat (LIMIT_CLKS) @(posedge CLK);
		$display("timeout: no result after %0d clocks in test %s", LIMIT_CLKS, testName);
		$display("errors: %0d pixel mismatches, %0d other, %0d assertion failures",
			mismatchCount, otherCount, u_dut.u_chk.failCount);
		$display("Regression failed");
		$finish;
	end

	initial begin
		int n, snap, rnd, total;
		logic prevH;
		logic [3:0] sel;
		kernelT curK, newK;
		seed = 32'hedd85887;
		rstN = 1'b0;
		{identity, kernel1, kernel2, kernel3} = 4'b0000;
		testName = "reset";
		repeat (3) @(posedge CLK);
		rstN <= 1'b1;
		@(negedge CLK);
		assert (hsync && vsync && !filterDone)
		else begin
			otherCount++;
			$display("MISMATCH reset hsync,vsync,done expected 110 actual %b%b%b",
				hsync, vsync, filterDone);
		end

		// line period, fall to fall
		testName = "timing";
		while (hsync !== 1'b1)
			@(negedge CLK);
		while (hsync !== 1'b0)
			@(negedge CLK);
		n = 0;
		do begin
			prevH = hsync;
			@(negedge CLK);
			n++;
		end while (!(prevH === 1'b1 && hsync === 1'b0));
		assert (n == LINE_CLKS)
		else begin
			otherCount++;
			$display("MISMATCH timing hsync period expected %0d actual %0d", LINE_CLKS, n);
		end

		// visible clocks from vsync release to the next vsync
		while (vsync !== 1'b0)
			@(negedge CLK);
		while (vsync !== 1'b1)
			@(negedge CLK);
		n = 0;
		while (vsync !== 1'b0) begin
			@(negedge CLK);
			if (blank === 1'b1)
				n++;
		end
		assert (n == FRAME_PIX * `PIX_DIV)
		else begin
			otherCount++;
			$display("MISMATCH timing blank clocks per frame expected %0d actual %0d",
				FRAME_PIX * `PIX_DIV, n);
		end

		// first pass after reset runs the identity kernel
		waitDone(0);
		checkFrame("identity", kIdentity);

		runKernel("blur", selFor(kBlur), kBlur);
		runKernel("sharpen", selFor(kSharpen), kSharpen);
		runKernel("edge", selFor(kEdge), kEdge);
		// kernel1 wins over kernel3
		runKernel("priority", 4'b1010, kBlur);

		// second select lands while the first pass still runs
		testName = "restart";
		snap = doneCount;
		pulseSel(selFor(kSharpen));
		repeat (PASS_CLKS / 4) @(posedge CLK);
		pulseSel(selFor(kEdge));
		waitDone(snap);
		checkFrame("restart", kEdge);
		assert (doneCount == snap + 1)
		else begin
			otherCount++;
			$display("MISMATCH restart done pulses expected 1 actual %0d", doneCount - snap);
		end
		curK = kEdge;

		// seeded selects, a repeat of the current kernel starts no pass
		for (int step = 0; step < RAND_STEPS; step++) begin
			rnd = $random(seed);
			sel = rnd[3:0];
			if (sel == 4'b0000)
				sel = selFor(curK);
			newK = nextKernel(sel, curK);
			testName = $sformatf("random%0d", step);
			snap = doneCount;
			pulseSel(sel);
			if (newK != curK) begin
				waitDone(snap);
			end else begin
				// any pass would have ended by now
				repeat (PASS_CLKS + 4) @(posedge CLK);
				assert (doneCount == snap)
				else begin
					otherCount++;
					$display("repeated select of the current kernel started a pass in %s",
						testName);
				end
			end
			checkFrame(testName, newK);
			curK = newK;
		end

		total = mismatchCount + otherCount + u_dut.u_chk.failCount;
		$display("errors: %0d pixel mismatches, %0d other, %0d assertion failures",
			mismatchCount, otherCount, u_dut.u_chk.failCount);
		if (total == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- imgFilter.f
+incdir+hdl
hdl/imgFilterPkg.sv
hdl/convEngine.sv
hdl/frameBuffer.sv
hdl/videoScanner.sv
hdl/imgFilter.sv
bench/imgFilter_chk.sv
bench/imgFilterTb.sv

//--- Makefile
TOP = imgFilterTb
FLIST = imgFilter.f

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f $(FLIST) -Mdir obj_dir -o simv
	./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
